// ==== common/em_write_settings.svh ====
// width and depth macros shared by the host write bridge, include wherever a size is needed
`ifndef EM_WRITE_SETTINGS_SVH
`define EM_WRITE_SETTINGS_SVH

// width of the host data bus in bits
`define EM_DATA_W 16

// log2 of the FIFO depth
// 10 gives 1024 tagged words of storage
`define EM_FIFO_AW 10

// the host may start a burst only while the FIFO space is above this value
// with a 1024 word FIFO this means the FIFO has fully drained
`define EM_READY_SPACE 1023

// flags carried above the data word in a tagged word
// bit 16 is start of frame, bit 17 is end of frame
`define EM_TAG_W 2

`endif

// ==== common/em_write_pkg.sv ====
// vector types for the host write bridge, referenced by scoped name from RTL and testbench
`default_nettype none

`include "em_write_settings.svh"

package em_write_pkg;

   // one word as written by the host processor
   typedef logic [`EM_DATA_W-1:0] host_word_t;

   // a host word with its frame flags on top
   // bit 17 is end of frame, bit 16 is start of frame, bits 15..0 are the data
   typedef logic [`EM_DATA_W+`EM_TAG_W-1:0] tagged_word_t;

   // frame length setting and the running position inside a frame
   typedef logic [15:0] frame_len_t;

   // free word count of the FIFO
   // 16 bits so that the empty count of 1024 fits
   typedef logic [15:0] fifo_space_t;

endpackage

`default_nettype wire

// ==== common/tagged_stream_if.sv ====
// tagged word stream with src_rdy/dst_rdy from the frame writer into the FIFO write side
`timescale 1ns/1ps
`default_nettype none

interface tagged_stream_if;

   // tagged word offered by the writer
   em_write_pkg::tagged_word_t data;

   // writer has a word this cycle
   // it is a single cycle pulse per host strobe and never waits
   logic src_rdy;

   // FIFO can take a word this cycle
   // a src_rdy pulse while this is low loses the word
   logic dst_rdy;

   // free words left in the FIFO, seen from the write clock
   em_write_pkg::fifo_space_t space;

   // producer side, owns the word and its valid
   modport writer (output data, output src_rdy, input dst_rdy, input space);

   // consumer side, reports room and takes the word
   modport fifo (input data, input src_rdy, output dst_rdy, output space);

endinterface

`default_nettype wire

// ==== async_fifo/fifo_ram.sv ====
// simple dual-port storage for the two-clock FIFO, written in bus_clk and read in fifo_clk
`timescale 1ns/1ps
`default_nettype none

`include "em_write_settings.svh"

module fifo_ram
(
   input  wire                          bus_clk,
   input  wire                          wr_en_i,
   input  wire [`EM_FIFO_AW-1:0]        wr_addr_i,
   input  wire em_write_pkg::tagged_word_t wr_data_i,
   input  wire                          fifo_clk,
   input  wire                          rd_en_i,
   input  wire [`EM_FIFO_AW-1:0]        rd_addr_i,
   output em_write_pkg::tagged_word_t   rd_data_o
);

   localparam int DEPTH = 1 << `EM_FIFO_AW;

   // one tagged word per FIFO slot, indexed by the low pointer bits
   em_write_pkg::tagged_word_t mem [DEPTH];

   always_ff @(posedge bus_clk)
   begin
      if (wr_en_i)
         mem[wr_addr_i] <= wr_data_i;
   end

   // the read register only loads on rd_en_i and so holds the word at the
   // head of the FIFO while the sink stalls
   always_ff @(posedge fifo_clk)
   begin
      if (rd_en_i)
         rd_data_o <= mem[rd_addr_i];
   end

endmodule

`default_nettype wire

// ==== async_fifo/async_fifo.sv ====
// two-clock FIFO with Gray pointers, taking tagged words in bus_clk and streaming them in fifo_clk
`timescale 1ns/1ps
`default_nettype none

`include "em_write_settings.svh"

module async_fifo
(
   input  wire                        bus_clk,
   input  wire                        fifo_clk,
   input  wire                        fifo_rst,
   tagged_stream_if.fifo              wr_if,
   output em_write_pkg::tagged_word_t data_o,
   output logic                       src_rdy_o,
   input  wire                        dst_rdy_i
);

   localparam int AW    = `EM_FIFO_AW;
   localparam int DEPTH = 1 << AW;

   // pointers carry one extra bit so that full and empty can be told apart
   logic [AW:0] wr_bin_q;
   logic [AW:0] wr_gray_q;
   logic [AW:0] wr_bin_next;
   logic [AW:0] rd_gray_s1;
   logic [AW:0] rd_gray_s2;
   logic [AW:0] wr_used;
   logic        wr_full;
   logic        wr_en;

   logic [1:0]  rd_rst_pipe;
   logic        rd_rst;
   logic [AW:0] rd_bin_q;
   logic [AW:0] rd_gray_q;
   logic [AW:0] rd_bin_next;
   logic [AW:0] wr_gray_s1;
   logic [AW:0] wr_gray_s2;
   logic        rd_empty;
   logic        rd_en;

   function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
      logic [AW:0] b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--)
         b[i] = b[i+1] ^ g[i];
      return b;
   endfunction

   // write side in bus_clk

   // full when the synchronized read pointer is exactly one lap behind,
   // which in Gray code means the two top bits are inverted
   assign wr_full = (wr_gray_q == {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]});
   assign wr_en   = wr_if.src_rdy & ~wr_full;
   assign wr_bin_next = wr_bin_q + 1'b1;

   // the used count lags real reads by the two synchronizer stages, so space
   // drops on the write edge at once but recovers a few cycles after a read
   assign wr_used       = wr_bin_q - gray2bin(rd_gray_s2);
   assign wr_if.space   = em_write_pkg::fifo_space_t'(DEPTH)
                          - em_write_pkg::fifo_space_t'(wr_used);
   assign wr_if.dst_rdy = ~wr_full;

   always_ff @(posedge bus_clk)
   begin
      if (fifo_rst)
      begin
         wr_bin_q   <= '0;
         wr_gray_q  <= '0;
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end
      else
      begin
         rd_gray_s1 <= rd_gray_q;
         rd_gray_s2 <= rd_gray_s1;
         if (wr_en)
         begin
            wr_bin_q  <= wr_bin_next;
            wr_gray_q <= wr_bin_next ^ (wr_bin_next >> 1);
         end
      end
   end

   // read side in fifo_clk

   // fifo_rst belongs to bus_clk, so the read side sees a delayed copy of it
   always_ff @(posedge fifo_clk)
   begin
      rd_rst_pipe <= {rd_rst_pipe[0], fifo_rst};
   end
   assign rd_rst = rd_rst_pipe[1];

   assign rd_empty    = (rd_gray_q == wr_gray_s2);
   assign rd_bin_next = rd_bin_q + 1'b1;

   // fetch the next word when the output register is empty or being taken
   assign rd_en = ~rd_empty & (~src_rdy_o | dst_rdy_i);

   always_ff @(posedge fifo_clk)
   begin
      if (rd_rst)
      begin
         rd_bin_q   <= '0;
         rd_gray_q  <= '0;
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
         src_rdy_o  <= 1'b0;
      end
      else
      begin
         wr_gray_s1 <= wr_gray_q;
         wr_gray_s2 <= wr_gray_s1;
         if (rd_en)
         begin
            rd_bin_q  <= rd_bin_next;
            rd_gray_q <= rd_bin_next ^ (rd_bin_next >> 1);
         end
         // show-ahead valid follows the RAM read register one cycle later
         if (rd_en)
            src_rdy_o <= 1'b1;
         else if (dst_rdy_i)
            src_rdy_o <= 1'b0;
      end
   end

   fifo_ram u_ram
   (
      .bus_clk   (bus_clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_bin_q[AW-1:0]),
      .wr_data_i (wr_if.data),
      .fifo_clk  (fifo_clk),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_bin_q[AW-1:0]),
      .rd_data_o (data_o)
   );

endmodule

`default_nettype wire

// ==== verilog/em_frame_writer.sv ====
// host write path that samples the memory bus pins, tags words with frame flags and feeds the FIFO
`timescale 1ns/1ps
`default_nettype none

`include "em_write_settings.svh"

module em_frame_writer
(
   input  wire                        bus_clk,
   input  wire                        fifo_clk,
   input  wire                        fifo_rst,
   input  wire                        clear_i,
   input  wire em_write_pkg::host_word_t  em_d_i,
   input  wire                        em_ncs_i,
   input  wire                        em_nwe_i,
   input  wire em_write_pkg::frame_len_t  frame_len_i,
   output em_write_pkg::tagged_word_t data_o,
   output logic                       src_rdy_o,
   input  wire                        dst_rdy_i,
   output logic                       fifo_ready_o,
   output logic                       bus_error_o
);

   // two stage samples of the asynchronous host pins
   // index 1 is the older sample
   logic [1:0]                 cs_del;
   logic [1:0]                 we_del;
   em_write_pkg::host_word_t   data_del0;
   em_write_pkg::host_word_t   data_del1;

   em_write_pkg::frame_len_t   pos_q;
   em_write_pkg::frame_len_t   pos_next;
   logic                       first_word;
   logic                       last_word;
   logic                       strobe;

   tagged_stream_if stream ();

   // chip select and write enable idle high, so reset parks them there to
   // avoid a false strobe as reset releases
   always_ff @(posedge bus_clk)
   begin
      if (fifo_rst)
      begin
         cs_del <= 2'b11;
         we_del <= 2'b11;
      end
      else
      begin
         cs_del <= {cs_del[0], em_ncs_i};
         we_del <= {we_del[0], em_nwe_i};
      end
   end

   // the data word is only used two samples later, when the strobe is seen
   always_ff @(posedge bus_clk)
   begin
      data_del0 <= em_d_i;
      data_del1 <= data_del0;
   end

   // write is done on the rising edge of nWE while chip select is still low
   assign strobe = ~cs_del[1] & ~we_del[1] & we_del[0];

   // frame flags come straight from the position counter in the strobe cycle
   assign pos_next   = pos_q + 1'b1;
   assign first_word = (pos_q == '0);
   assign last_word  = (pos_next == frame_len_i);

   always_ff @(posedge bus_clk)
   begin
      if (fifo_rst | clear_i)
         pos_q <= '0;
      else if (strobe)
      begin
         // the counter also advances for a dropped word, so the host stays
         // aligned to its own idea of the frame
         if (last_word)
            pos_q <= '0;
         else
            pos_q <= pos_next;
      end
   end

   assign stream.data    = {last_word, first_word, data_del1};
   assign stream.src_rdy = strobe;

   // ready for a new burst only when the whole FIFO has room
   always_ff @(posedge bus_clk)
   begin
      if (fifo_rst | clear_i)
         fifo_ready_o <= 1'b0;
      else
         fifo_ready_o <= (stream.space > `EM_READY_SPACE);
   end

   // a strobe cannot be stalled, so a word arriving at a full FIFO is lost
   // and the host learns of it through this sticky flag
   always_ff @(posedge bus_clk)
   begin
      if (fifo_rst | clear_i)
         bus_error_o <= 1'b0;
      else if (strobe & ~stream.dst_rdy)
         bus_error_o <= 1'b1;
   end

   async_fifo u_fifo
   (
      .bus_clk   (bus_clk),
      .fifo_clk  (fifo_clk),
      .fifo_rst  (fifo_rst),
      .wr_if     (stream.fifo),
      .data_o    (data_o),
      .src_rdy_o (src_rdy_o),
      .dst_rdy_i (dst_rdy_i)
   );

endmodule

`default_nettype wire

// ==== verilog/em_write_top.sv ====
// top level of the host write bridge with plain pins for the host bus, the stream and status
`timescale 1ns/1ps
`default_nettype none

module em_write_top
(
   // asynchronous host memory bus pins
   input  wire em_write_pkg::host_word_t  em_d_i,
   input  wire                        em_ncs_i,
   input  wire                        em_nwe_i,

   // clocks and the bus_clk side reset
   input  wire                        bus_clk,
   input  wire                        fifo_clk,
   input  wire                        fifo_rst,

   // control from the host register map
   input  wire                        clear_i,
   input  wire em_write_pkg::frame_len_t  frame_len_i,

   // tagged word stream in fifo_clk
   output em_write_pkg::tagged_word_t data_o,
   output logic                       src_rdy_o,
   input  wire                        dst_rdy_i,

   // status back to the host, in bus_clk
   output logic                       fifo_ready_o,
   output logic                       bus_error_o
);

   em_frame_writer u_writer
   (
      .bus_clk      (bus_clk),
      .fifo_clk     (fifo_clk),
      .fifo_rst     (fifo_rst),
      .clear_i      (clear_i),
      .em_d_i       (em_d_i),
      .em_ncs_i     (em_ncs_i),
      .em_nwe_i     (em_nwe_i),
      .frame_len_i  (frame_len_i),
      .data_o       (data_o),
      .src_rdy_o    (src_rdy_o),
      .dst_rdy_i    (dst_rdy_i),
      .fifo_ready_o (fifo_ready_o),
      .bus_error_o  (bus_error_o)
   );

endmodule

`default_nettype wire

// ==== dv/em_write_checker.sv ====
// stream and status monitor for the host write bridge testbench, holds the expected word queue
`timescale 1ns/1ps
`default_nettype none

module em_write_checker
(
   input wire                             fifo_clk,
   input wire em_write_pkg::tagged_word_t data_i,
   input wire                             src_rdy_i,
   input wire                             dst_rdy_i,
   input wire                             fifo_ready_i,
   input wire                             bus_error_i
);

   // words the stream must still deliver, oldest first
   em_write_pkg::tagged_word_t exp_q [$];

   string test_name;
   int    test_errors;
   int    pass_count;
   int    fail_count;

   initial
   begin
      test_name   = "startup";
      test_errors = 0;
      pass_count  = 0;
      fail_count  = 0;
   end

   // a word moves on a fifo_clk edge where both sides are ready
   always @(posedge fifo_clk)
   begin : compare_stream
      em_write_pkg::tagged_word_t exp_word;
      if (src_rdy_i === 1'b1 && dst_rdy_i === 1'b1)
      begin
         if (exp_q.size() == 0)
         begin
            $display("test %s: the stream delivered word %h that nobody expected",
                     test_name, data_i);
            test_errors++;
         end
         else
         begin
            exp_word = exp_q.pop_front();
            if (data_i !== exp_word)
            begin
               $display("Mismatch in %s: expected %h, actual %h",
                        test_name, exp_word, data_i);
               test_errors++;
            end
         end
      end
   end

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic expect_word(input em_write_pkg::tagged_word_t w);
      exp_q.push_back(w);
   endtask

   function automatic int pending();
      return exp_q.size();
   endfunction

   // failures that are not a wrong value, such as a timeout inside a test
   task automatic report_failure(input string msg);
      $display("test %s: %s", test_name, msg);
      test_errors++;
   endtask

   task automatic check_ready_flag(input logic exp_val);
      if (fifo_ready_i !== exp_val)
      begin
         $display("Mismatch in %s fifo_ready_o: expected %b, actual %b",
                  test_name, exp_val, fifo_ready_i);
         test_errors++;
      end
   endtask

   task automatic check_error_flag(input logic exp_val);
      if (bus_error_i !== exp_val)
      begin
         $display("Mismatch in %s bus_error_o: expected %b, actual %b",
                  test_name, exp_val, bus_error_i);
         test_errors++;
      end
   endtask

   task automatic end_test();
      if (test_errors == 0)
         pass_count++;
      else
         fail_count++;
      $display("test %s finished with %0d errors, result %s",
               test_name, test_errors, (test_errors == 0) ? "PASS" : "FAIL");
   endtask

   task automatic summary();
      $display("summary: %0d passing, %0d failing tests", pass_count, fail_count);
   endtask

endmodule

`default_nettype wire

// ==== dv/em_write_tb.sv ====
// testbench top for the host write bridge that drives host writes and sink back-pressure into the DUT
`timescale 1ns/1ps
`default_nettype none

`include "em_write_settings.svh"

module em_write_tb;

   // the RAM holds a full depth and the show-ahead register one more word
   localparam int CAPACITY    = (1 << `EM_FIFO_AW) + 1;
   localparam int TOTAL_WORDS = 3 + 8 + 21 + 200 + 1030 + 11;
   localparam int WATCHDOG_NS = TOTAL_WORDS * 40 + 20000;
   localparam int DRAIN_LIMIT = 4000;

   logic                       bus_clk;
   logic                       fifo_clk;
   logic                       fifo_rst;
   logic                       clear_i;
   logic                       em_ncs_i;
   logic                       em_nwe_i;
   logic                       dst_rdy_i;
   em_write_pkg::host_word_t   em_d_i;
   em_write_pkg::frame_len_t   frame_len_i;
   em_write_pkg::tagged_word_t data_o;
   logic                       src_rdy_o;
   logic                       fifo_ready_o;
   logic                       bus_error_o;

   integer                     seed;
   // sink behaviour is 0 for always ready, 1 for stalled and 2 for random
   int                         sink_mode;
   em_write_pkg::frame_len_t   pos;

   initial
   begin
      bus_clk = 1'b0;
      forever #2 bus_clk = ~bus_clk;
   end

   initial
   begin
      fifo_clk = 1'b0;
      forever #3 fifo_clk = ~fifo_clk;
   end

   em_write_top dut
   (
      .em_d_i       (em_d_i),
      .em_ncs_i     (em_ncs_i),
      .em_nwe_i     (em_nwe_i),
      .bus_clk      (bus_clk),
      .fifo_clk     (fifo_clk),
      .fifo_rst     (fifo_rst),
      .clear_i      (clear_i),
      .frame_len_i  (frame_len_i),
      .data_o       (data_o),
      .src_rdy_o    (src_rdy_o),
      .dst_rdy_i    (dst_rdy_i),
      .fifo_ready_o (fifo_ready_o),
      .bus_error_o  (bus_error_o)
   );

   em_write_checker chk
   (
      .fifo_clk     (fifo_clk),
      .data_i       (data_o),
      .src_rdy_i    (src_rdy_o),
      .dst_rdy_i    (dst_rdy_i),
      .fifo_ready_i (fifo_ready_o),
      .bus_error_i  (bus_error_o)
   );

   // the sink changes dst_rdy_i just after each fifo_clk edge
   initial
   begin
      dst_rdy_i = 1'b1;
      forever
      begin
         @(posedge fifo_clk);
         #1;
         if (sink_mode == 1)
            dst_rdy_i = 1'b0;
         else if (sink_mode == 2)
            dst_rdy_i = ($random(seed) & 1) == 1;
         else
            dst_rdy_i = 1'b1;
      end
   end

   // SOF on position 0, EOF on the last position of the frame
   function automatic em_write_pkg::tagged_word_t tag_word(
      input em_write_pkg::host_word_t d,
      input em_write_pkg::frame_len_t p,
      input em_write_pkg::frame_len_t len);
      logic sof;
      logic eof;
      sof = (p == 0);
      eof = (p + 16'd1 == len);
      return {eof, sof, d};
   endfunction

   task automatic bus_cycles(input int n);
      repeat (n) @(posedge bus_clk);
      #1;
   endtask

   // nWE rises while nCS is still low, and data stays put until the next write
   task automatic host_write(input em_write_pkg::host_word_t d);
      em_d_i   = d;
      em_ncs_i = 1'b0;
      em_nwe_i = 1'b0;
      bus_cycles(4);
      em_nwe_i = 1'b1;
      bus_cycles(2);
      em_ncs_i = 1'b1;
      bus_cycles(1);
   endtask

   // the position advances even for a word the FIFO drops
   task automatic write_tagged(input bit accepted);
      integer r;
      em_write_pkg::host_word_t d;
      r = $random(seed);
      d = r[`EM_DATA_W-1:0];
      if (accepted)
         chk.expect_word(tag_word(d, pos, frame_len_i));
      host_write(d);
      if (pos + 16'd1 == frame_len_i)
         pos = 0;
      else
         pos = pos + 16'd1;
   endtask

   task automatic send_frame(input em_write_pkg::frame_len_t len);
      frame_len_i = len;
      for (int i = 0; i < len; i++)
         write_tagged(1'b1);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (chk.pending() != 0 && n < DRAIN_LIMIT)
      begin
         @(posedge fifo_clk);
         n++;
      end
      if (chk.pending() != 0)
         chk.report_failure("the stream did not deliver every expected word in time");
      bus_cycles(1);
   endtask

   // space comes back a few bus_clk cycles after the last read
   task automatic wait_ready();
      int n;
      n = 0;
      while (fifo_ready_o !== 1'b1 && n < 20)
      begin
         bus_cycles(1);
         n++;
      end
      if (fifo_ready_o !== 1'b1)
         chk.report_failure("fifo_ready_o did not return high after the FIFO drained");
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the test sequence finished");
      $display("Test failed");
      $finish;
   end

   initial
   begin
      seed        = 55289;
      sink_mode   = 0;
      pos         = 0;
      fifo_rst    = 1'b1;
      clear_i     = 1'b0;
      em_ncs_i    = 1'b1;
      em_nwe_i    = 1'b1;
      em_d_i      = '0;
      frame_len_i = 16'd8;
      bus_cycles(5);
      fifo_rst = 1'b0;
      bus_cycles(2);

      // two words sit in the RAM behind the one held at the output
      // the three words form one whole frame so the next test starts at position 0
      chk.start_test("ready_flag");
      chk.check_ready_flag(1'b1);
      sink_mode = 1;
      frame_len_i = 16'd3;
      bus_cycles(2);
      for (int i = 0; i < 3; i++)
         write_tagged(1'b1);
      bus_cycles(2);
      chk.check_ready_flag(1'b0);
      sink_mode = 0;
      wait_drain();
      wait_ready();
      chk.check_error_flag(1'b0);
      chk.end_test();

      chk.start_test("one_frame");
      frame_len_i = 16'd8;
      send_frame(16'd8);
      wait_drain();
      chk.check_error_flag(1'b0);
      chk.end_test();

      chk.start_test("mixed_frames");
      send_frame(16'd1);
      send_frame(16'd3);
      send_frame(16'd17);
      wait_drain();
      chk.check_error_flag(1'b0);
      chk.end_test();

      chk.start_test("random_backpressure");
      sink_mode = 2;
      frame_len_i = 16'd20;
      for (int i = 0; i < 200; i++)
         write_tagged(1'b1);
      sink_mode = 0;
      wait_drain();
      chk.check_error_flag(1'b0);
      chk.end_test();

      // 1030 words into a stalled sink with frames of 10 so the count ends aligned
      chk.start_test("overflow");
      sink_mode = 1;
      frame_len_i = 16'd10;
      bus_cycles(2);
      for (int i = 0; i < 1030; i++)
         write_tagged(i < CAPACITY);
      chk.check_error_flag(1'b1);
      sink_mode = 0;
      wait_drain();
      repeat (50) @(posedge fifo_clk);
      bus_cycles(1);
      chk.end_test();

      chk.start_test("clear");
      frame_len_i = 16'd8;
      for (int i = 0; i < 3; i++)
         write_tagged(1'b1);
      chk.check_error_flag(1'b1);
      clear_i = 1'b1;
      bus_cycles(1);
      clear_i = 1'b0;
      pos = 0;
      bus_cycles(1);
      chk.check_error_flag(1'b0);
      for (int i = 0; i < 8; i++)
         write_tagged(1'b1);
      wait_drain();
      chk.end_test();

      chk.summary();
      if (chk.fail_count == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/em_write_pkg.sv
common/tagged_stream_if.sv
async_fifo/fifo_ram.sv
async_fifo/async_fifo.sv
verilog/em_frame_writer.sv
verilog/em_write_top.sv
dv/em_write_checker.sv
dv/em_write_tb.sv
